// ==== logic/vec_cfg_pkg.sv ====
////////////////////////////////////////////////////////////
// Vector configuration types shared by the store buffer
// Element width codes, register length and lane word types
////////////////////////////////////////////////////////////
package vec_cfg_pkg;

  // Element width code, also the log2 of the element bytes
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_e;

  typedef logic [31:0] lane_word_t;  // One lane RAM word
  typedef logic [7:0]  vlenb_t;      // Vector register length in bytes

  localparam int WORD_BYTES = 4;

endpackage

// ==== logic/mem_xfer_pkg.sv ====
////////////////////////////////////////////////////////////
// Memory write channel types for the store buffer
// Store types, byte addresses, transfer sizes and strobes
////////////////////////////////////////////////////////////
package mem_xfer_pkg;

  // Store addressing mode
  typedef enum logic {
    ST_UNIT    = 1'b0,
    ST_STRIDED = 1'b1
  } store_type_e;

  typedef logic [31:0] addr_t;       // Byte address
  typedef logic [15:0] xfer_size_t;  // Transfer length in bytes
  typedef logic [3:0]  strb_t;       // Byte strobe of one bus word

  localparam strb_t STRB_ALL = 4'b1111;

endpackage

// ==== logic/store_len_calc.sv ====
////////////////////////////////////////////////////////////
// Store length calculator
// Registers write beats, read beats and transfer size on cfg_update_i
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module store_len_calc #(
  parameter  int LANES = 4,
  parameter  int DEPTH = 8,
  localparam int WB_W  = $clog2(DEPTH * vec_cfg_pkg::WORD_BYTES + 1),
  localparam int RB_W  = $clog2(LANES * DEPTH * vec_cfg_pkg::WORD_BYTES + 1)
) (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      cfg_update_i,
  input  vec_cfg_pkg::sew_e         sew_i,
  input  logic                      lmul_grow_i,
  input  logic [1:0]                lmul_shift_i,
  input  vec_cfg_pkg::vlenb_t       vlenb_i,
  input  mem_xfer_pkg::store_type_e store_type_i,
  output logic [WB_W-1:0]           wr_beats_o,
  output logic [RB_W-1:0]           rd_beats_o,
  output mem_xfer_pkg::xfer_size_t  xfer_size_o
);

  localparam int LSH = $clog2(LANES);

  mem_xfer_pkg::xfer_size_t total_bytes;
  mem_xfer_pkg::xfer_size_t elem_cnt;
  mem_xfer_pkg::xfer_size_t rd_beats_nxt;
  mem_xfer_pkg::xfer_size_t xfer_nxt;
  logic                     unit_mode;

  ////////////////////////////////////////////////////////////
  // Register group scaling

  assign total_bytes = lmul_grow_i ? (16'(vlenb_i) << lmul_shift_i)
                                   : (16'(vlenb_i) >> lmul_shift_i);
  assign elem_cnt    = total_bytes >> sew_i;  // Code is log2 of element bytes
  assign unit_mode   = (store_type_i == mem_xfer_pkg::ST_UNIT);

  // Unit stride moves whole words, strided moves one element per beat
  assign rd_beats_nxt = unit_mode ? (total_bytes >> 2) : elem_cnt;
  assign xfer_nxt     = unit_mode ? total_bytes : (16'd1 << sew_i);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_beats_o  <= '0;
      rd_beats_o  <= '0;
      xfer_size_o <= '0;
    end else if (cfg_update_i) begin
      wr_beats_o  <= WB_W'(elem_cnt >> LSH);  // All lanes deliver per beat
      rd_beats_o  <= RB_W'(rd_beats_nxt);
      xfer_size_o <= xfer_nxt;
    end
  end

endmodule

// ==== logic/lane_pack_writer.sv ====
////////////////////////////////////////////////////////////
// Lane pack writer
// Packs narrow lane elements into stream words and drives the lane RAM writes
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module lane_pack_writer #(
  parameter  int LANES = 4,
  parameter  int DEPTH = 8,
  localparam int WB_W  = $clog2(DEPTH * vec_cfg_pkg::WORD_BYTES + 1),
  localparam int RW    = $clog2(DEPTH)
) (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    cntr_rst_i,
  input  logic                    wen_i,
  input  vec_cfg_pkg::sew_e       sew_i,
  input  logic [WB_W-1:0]         wr_beats_i,
  input  vec_cfg_pkg::lane_word_t lane_data_i [LANES],
  output mem_xfer_pkg::strb_t     wr_be_o     [LANES],
  output logic [RW-1:0]           wr_row_o,
  output vec_cfg_pkg::lane_word_t wr_data_o   [LANES],
  output logic                    not_empty_o,
  output logic                    write_done_o
);

  logic [WB_W-1:0] wr_cnt;  // Write beats taken since counter reset

  always_ff @(posedge clk) begin
    if (!rstn || cntr_rst_i) begin
      wr_cnt       <= '0;
      write_done_o <= 1'b0;
    end else if (wen_i) begin
      wr_cnt <= wr_cnt + 1'b1;
      if (wr_cnt + 1'b1 == wr_beats_i) begin
        write_done_o <= 1'b1;
      end
    end
  end

  assign not_empty_o = (wr_cnt != '0);

  // All words of one beat fall into the same row
  // SEW32 fills a row per beat, SEW16 every second, SEW8 every fourth
  assign wr_row_o = RW'(wr_cnt >> (2'd2 - sew_i));

  ////////////////////////////////////////////////////////////
  // Per RAM gather and byte enables

  for (genvar r = 0; r < LANES; r++) begin : g_lane
    localparam int G16 = r / (LANES / 2);  // Beat parity that hits this RAM
    localparam int J16 = r % (LANES / 2);  // Lane pair feeding this RAM
    localparam int G8  = r / (LANES / 4);
    localparam int J8  = r % (LANES / 4);

    logic                    hit;
    vec_cfg_pkg::lane_word_t gdata;

    always_comb begin
      case (sew_i)
        vec_cfg_pkg::SEW16: begin
          hit   = (int'(wr_cnt[0]) == G16);
          gdata = {lane_data_i[2*J16+1][15:0], lane_data_i[2*J16][15:0]};
        end
        vec_cfg_pkg::SEW8: begin
          hit   = (int'(wr_cnt[1:0]) == G8);
          gdata = {lane_data_i[4*J8+3][7:0], lane_data_i[4*J8+2][7:0],
                   lane_data_i[4*J8+1][7:0], lane_data_i[4*J8][7:0]};
        end
        default: begin
          hit   = 1'b1;  // One word per lane
          gdata = lane_data_i[r];
        end
      endcase
    end

    assign wr_be_o[r]   = (wen_i && hit) ? mem_xfer_pkg::STRB_ALL : 4'b0000;
    assign wr_data_o[r] = gdata;
  end

  // Lanes must not push past the configured vector length
  a_no_wen_after_done: assert property (
    @(posedge clk) disable iff (!rstn) wen_i |-> !write_done_o
  );

endmodule

// ==== logic/lane_buffer_ram.sv ====
////////////////////////////////////////////////////////////
// One lane of the store buffer
// Simple dual port RAM, byte writes, read register and stallable output register
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module lane_buffer_ram #(
  parameter  int DEPTH = 8,
  localparam int RW    = $clog2(DEPTH)
) (
  input  logic                    clk,
  input  logic                    rstn,
  input  mem_xfer_pkg::strb_t     wr_be_i,
  input  logic [RW-1:0]           wr_row_i,
  input  vec_cfg_pkg::lane_word_t wr_data_i,
  input  logic                    rd_en_i,
  input  logic [RW-1:0]           rd_row_i,
  input  logic                    out_en_i,
  input  logic                    out_clr_i,
  output vec_cfg_pkg::lane_word_t rd_data_o
);

  vec_cfg_pkg::lane_word_t mem [DEPTH];
  vec_cfg_pkg::lane_word_t rd_q;

  always_ff @(posedge clk) begin
    for (int b = 0; b < vec_cfg_pkg::WORD_BYTES; b++) begin
      if (wr_be_i[b]) begin
        mem[wr_row_i][8*b +: 8] <= wr_data_i[8*b +: 8];
      end
    end
    if (rd_en_i) begin
      rd_q <= mem[rd_row_i];  // First read stage
    end
  end

  // Output register, cleared by reset or flush
  always_ff @(posedge clk) begin
    if (!rstn || out_clr_i) begin
      rd_data_o <= '0;
    end else if (out_en_i) begin
      rd_data_o <= rd_q;
    end
  end

  a_row_in_range: assert property (
    @(posedge clk) disable iff (!rstn)
    ((|wr_be_i) -> (wr_row_i < DEPTH)) && (rd_en_i -> (rd_row_i < DEPTH))
  );

endmodule

// ==== logic/store_serializer.sv ====
////////////////////////////////////////////////////////////
// Store serializer toward the 32-bit memory write channel
// Picks lane and row per read beat, tracks the address, rotates and strobes data
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module store_serializer #(
  parameter  int LANES = 4,
  parameter  int DEPTH = 8,
  localparam int RB_W  = $clog2(LANES * DEPTH * vec_cfg_pkg::WORD_BYTES + 1),
  localparam int RW    = $clog2(DEPTH)
) (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      cntr_rst_i,
  input  logic                      rd_en_i,
  input  logic                      stall_i,
  input  logic                      flush_i,
  input  vec_cfg_pkg::sew_e         sew_i,
  input  mem_xfer_pkg::store_type_e store_type_i,
  input  logic [RB_W-1:0]           rd_beats_i,
  input  logic                      addr_load_i,
  input  mem_xfer_pkg::addr_t       base_addr_i,
  input  mem_xfer_pkg::addr_t       stride_i,
  input  vec_cfg_pkg::lane_word_t   lane_rd_data_i [LANES],
  output logic                      ram_rd_en_o,
  output logic [RW-1:0]             ram_rd_row_o,
  output logic                      ram_out_en_o,
  output logic                      ram_out_clr_o,
  output vec_cfg_pkg::lane_word_t   wdata_o,
  output mem_xfer_pkg::strb_t       wstrb_o,
  output mem_xfer_pkg::addr_t       waddr_o,
  output logic                      wbeat_o,
  output logic                      read_done_o
);

  localparam int LSH = $clog2(LANES);

  logic [RB_W-1:0]     rd_cnt;
  logic [RB_W+1:0]     rd_pos;    // Stream byte position of the beat
  logic [RB_W-1:0]     rd_word;
  logic [LSH-1:0]      rd_lane;
  logic                strided;
  mem_xfer_pkg::addr_t base_q;
  mem_xfer_pkg::addr_t ofs_q;
  mem_xfer_pkg::addr_t cur_addr;
  mem_xfer_pkg::strb_t elem_strb;
  logic                s1_valid, s2_valid;
  logic [LSH-1:0]      s1_lane, s2_lane;
  logic [1:0]          s1_rot, s2_rot;
  mem_xfer_pkg::addr_t s1_addr, s2_addr;
  vec_cfg_pkg::lane_word_t sel_word;

  function automatic vec_cfg_pkg::lane_word_t rol_bytes(input vec_cfg_pkg::lane_word_t w,
                                                        input logic [1:0] n);
    case (n)
      2'd1:    return {w[23:0], w[31:24]};
      2'd2:    return {w[15:0], w[31:16]};
      2'd3:    return {w[7:0], w[31:8]};
      default: return w;
    endcase
  endfunction

  function automatic vec_cfg_pkg::lane_word_t strb_mask(input mem_xfer_pkg::strb_t s);
    vec_cfg_pkg::lane_word_t m;
    for (int i = 0; i < vec_cfg_pkg::WORD_BYTES; i++) begin
      m[8*i +: 8] = {8{s[i]}};
    end
    return m;
  endfunction

  ////////////////////////////////////////////////////////////
  // Read beat counter and lane RAM addressing

  assign strided  = (store_type_i == mem_xfer_pkg::ST_STRIDED);
  assign rd_pos   = strided ? ({2'b00, rd_cnt} << sew_i) : {rd_cnt, 2'b00};
  assign rd_word  = rd_pos[RB_W+1:2];
  assign rd_lane  = rd_word[LSH-1:0];          // Word w sits in lane w mod LANES
  assign cur_addr = strided ? (base_q + ofs_q) : base_q;

  assign ram_rd_en_o   = rd_en_i && !stall_i;
  assign ram_rd_row_o  = rd_word[LSH +: RW];
  assign ram_out_en_o  = s1_valid && !stall_i;
  assign ram_out_clr_o = flush_i;

  always_ff @(posedge clk) begin
    if (!rstn || cntr_rst_i) begin
      rd_cnt      <= '0;
      read_done_o <= 1'b0;
    end else if (rd_en_i) begin
      rd_cnt <= rd_cnt + 1'b1;
      if (rd_cnt + 1'b1 == rd_beats_i) begin
        read_done_o <= 1'b1;
      end
    end
  end

  // Element address, base plus accumulated stride
  always_ff @(posedge clk) begin
    if (addr_load_i) begin
      base_q <= base_addr_i;
      ofs_q  <= '0;
    end else if (rd_en_i && strided) begin
      ofs_q <= ofs_q + stride_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Two stage pipeline matching the RAM latency

  always_ff @(posedge clk) begin
    if (!rstn || flush_i) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else if (!stall_i) begin
      s1_valid <= rd_en_i;
      s2_valid <= s1_valid;
    end else begin
      s2_valid <= 1'b0;  // Beat already presented, data is held
    end
  end

  always_ff @(posedge clk) begin
    if (ram_rd_en_o) begin
      s1_lane <= rd_lane;
      s1_rot  <= strided ? (cur_addr[1:0] - rd_pos[1:0]) : 2'd0;
      s1_addr <= cur_addr;
    end
    if (ram_out_en_o) begin
      s2_lane <= s1_lane;
      s2_rot  <= s1_rot;
      s2_addr <= s1_addr;
    end
  end

  always_comb begin
    case (sew_i)
      vec_cfg_pkg::SEW8:  elem_strb = 4'b0001;
      vec_cfg_pkg::SEW16: elem_strb = 4'b0011;
      default:            elem_strb = 4'b1111;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn || flush_i) begin
      wstrb_o <= '0;
    end else if (ram_out_en_o) begin
      wstrb_o <= strided ? (elem_strb << s1_addr[1:0]) : mem_xfer_pkg::STRB_ALL;
    end
  end

  assign sel_word = lane_rd_data_i[s2_lane];
  assign wdata_o  = rol_bytes(sel_word, s2_rot) & strb_mask(wstrb_o);  // Unused bytes zero
  assign waddr_o  = s2_addr;
  assign wbeat_o  = s2_valid;

  a_no_read_in_stall: assert property (
    @(posedge clk) disable iff (!rstn) rd_en_i |-> !stall_i
  );

  a_strided_aligned: assert property (
    @(posedge clk) disable iff (!rstn)
    (s1_valid && strided) |-> ((s1_addr[1:0] & 2'((1 << sew_i) - 1)) == 2'b00)
  );

endmodule

// ==== logic/store_buffer_top.sv ====
////////////////////////////////////////////////////////////
// Vector store buffer top level
// Lanes write packed elements, the serializer streams them to memory
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module store_buffer_top #(
  parameter int LANES = 4,
  parameter int DEPTH = 8
) (
  input  logic                      clk,
  input  logic                      rstn,
  // Configuration
  input  logic                      cfg_update_i,
  input  vec_cfg_pkg::sew_e         sew_i,
  input  logic                      lmul_grow_i,
  input  logic [1:0]                lmul_shift_i,
  input  vec_cfg_pkg::vlenb_t       vlenb_i,
  input  mem_xfer_pkg::store_type_e store_type_i,
  input  logic                      cntr_rst_i,
  // Lane side
  input  logic                      wen_i,
  input  vec_cfg_pkg::lane_word_t   lane_data_i [LANES],
  // Memory side
  input  logic                      rd_en_i,
  input  logic                      stall_i,
  input  logic                      flush_i,
  input  logic                      addr_load_i,
  input  mem_xfer_pkg::addr_t       base_addr_i,
  input  mem_xfer_pkg::addr_t       stride_i,
  output vec_cfg_pkg::lane_word_t   wdata_o,
  output mem_xfer_pkg::strb_t       wstrb_o,
  output mem_xfer_pkg::addr_t       waddr_o,
  output logic                      wbeat_o,
  output mem_xfer_pkg::xfer_size_t  xfer_size_o,
  // Status
  output logic                      not_empty_o,
  output logic                      write_done_o,
  output logic                      read_done_o
);

  localparam int WB_W = $clog2(DEPTH * vec_cfg_pkg::WORD_BYTES + 1);
  localparam int RB_W = $clog2(LANES * DEPTH * vec_cfg_pkg::WORD_BYTES + 1);
  localparam int RW   = $clog2(DEPTH);

  logic [WB_W-1:0]         wr_beats;
  logic [RB_W-1:0]         rd_beats;
  mem_xfer_pkg::strb_t     wr_be        [LANES];
  logic [RW-1:0]           wr_row;
  vec_cfg_pkg::lane_word_t wr_data      [LANES];
  vec_cfg_pkg::lane_word_t lane_rd_data [LANES];
  logic                    ram_rd_en;
  logic [RW-1:0]           ram_rd_row;
  logic                    ram_out_en;
  logic                    ram_out_clr;

  store_len_calc #(.LANES(LANES), .DEPTH(DEPTH)) u_len_calc (
    .clk, .rstn, .cfg_update_i, .sew_i, .lmul_grow_i, .lmul_shift_i, .vlenb_i,
    .store_type_i, .wr_beats_o(wr_beats), .rd_beats_o(rd_beats), .xfer_size_o
  );

  lane_pack_writer #(.LANES(LANES), .DEPTH(DEPTH)) u_writer (
    .clk, .rstn, .cntr_rst_i, .wen_i, .sew_i, .wr_beats_i(wr_beats), .lane_data_i,
    .wr_be_o(wr_be), .wr_row_o(wr_row), .wr_data_o(wr_data), .not_empty_o, .write_done_o
  );

  for (genvar l = 0; l < LANES; l++) begin : g_ram
    lane_buffer_ram #(.DEPTH(DEPTH)) u_ram (
      .clk, .rstn, .wr_be_i(wr_be[l]), .wr_row_i(wr_row), .wr_data_i(wr_data[l]),
      .rd_en_i(ram_rd_en), .rd_row_i(ram_rd_row), .out_en_i(ram_out_en),
      .out_clr_i(ram_out_clr), .rd_data_o(lane_rd_data[l])
    );
  end

  store_serializer #(.LANES(LANES), .DEPTH(DEPTH)) u_serializer (
    .clk, .rstn, .cntr_rst_i, .rd_en_i, .stall_i, .flush_i, .sew_i, .store_type_i,
    .rd_beats_i(rd_beats), .addr_load_i, .base_addr_i, .stride_i,
    .lane_rd_data_i(lane_rd_data), .ram_rd_en_o(ram_rd_en), .ram_rd_row_o(ram_rd_row),
    .ram_out_en_o(ram_out_en), .ram_out_clr_o(ram_out_clr),
    .wdata_o, .wstrb_o, .waddr_o, .wbeat_o, .read_done_o
  );

endmodule

// ==== testbench/tb_store_buffer.sv ====
////////////////////////////////////////////////////////////
// Self-checking testbench for the vector store buffer
// Replays testbench/store_vectors.txt and checks every beat
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_store_buffer;

  localparam int LANES  = 4;
  localparam int DEPTH  = 8;
  localparam int PERIOD = 4;
  localparam logic [31:0] SEED = 32'h4f79_5823;

  logic                      clk = 1'b0;
  logic                      rstn;
  logic                      cfg_update, lmul_grow, cntr_rst, wen;
  logic                      rd_en, stall, flush, addr_load;
  logic [1:0]                lmul_shift;
  vec_cfg_pkg::sew_e         sew;
  vec_cfg_pkg::vlenb_t       vlenb;
  mem_xfer_pkg::store_type_e store_type;
  mem_xfer_pkg::addr_t       base_addr, stride, waddr;
  vec_cfg_pkg::lane_word_t   lane_data [LANES];
  vec_cfg_pkg::lane_word_t   wdata;
  mem_xfer_pkg::strb_t       wstrb;
  mem_xfer_pkg::xfer_size_t  xfer_size;
  logic                      wbeat, not_empty, write_done, read_done;

  // Expected beats in read order
  vec_cfg_pkg::lane_word_t  exp_data [$];
  mem_xfer_pkg::strb_t      exp_strb [$];
  mem_xfer_pkg::addr_t      exp_addr [$];
  mem_xfer_pkg::xfer_size_t exp_size [$];
  int                       issue_q  [$];  // Unstalled edge count at each read pulse

  string lines [$];
  logic  loaded = 1'b0;
  int    mismatches = 0;
  int    other_errs = 0;
  int    beats_seen = 0;
  int    ucnt = 0;
  int    wr_cnt, rd_cnt, exp_wr_beats, exp_rd_beats;

  always #(PERIOD / 2) clk = ~clk;

  store_buffer_top #(.LANES(LANES), .DEPTH(DEPTH)) UUT (
    .clk(clk), .rstn(rstn), .cfg_update_i(cfg_update), .sew_i(sew),
    .lmul_grow_i(lmul_grow), .lmul_shift_i(lmul_shift), .vlenb_i(vlenb),
    .store_type_i(store_type), .cntr_rst_i(cntr_rst), .wen_i(wen),
    .lane_data_i(lane_data), .rd_en_i(rd_en), .stall_i(stall), .flush_i(flush),
    .addr_load_i(addr_load), .base_addr_i(base_addr), .stride_i(stride),
    .wdata_o(wdata), .wstrb_o(wstrb), .waddr_o(waddr), .wbeat_o(wbeat),
    .xfer_size_o(xfer_size), .not_empty_o(not_empty), .write_done_o(write_done),
    .read_done_o(read_done)
  );

  ////////////////////////////////////////////////////////////
  // Compare tasks

  task automatic check_word(input string name, input vec_cfg_pkg::lane_word_t got,
                            input vec_cfg_pkg::lane_word_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_strb(input string name, input mem_xfer_pkg::strb_t got,
                            input mem_xfer_pkg::strb_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_addr(input string name, input mem_xfer_pkg::addr_t got,
                            input mem_xfer_pkg::addr_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_size(input string name, input mem_xfer_pkg::xfer_size_t got,
                            input mem_xfer_pkg::xfer_size_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp,
                             input string when);
    if (got !== exp) begin
      $display("Status error: %s should be %s %s", name, exp ? "high" : "low", when);
      other_errs++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Beat capture, sampled mid cycle

  always @(posedge clk) begin
    if (rstn) begin
      if (!stall) ucnt++;
      if (rd_en) issue_q.push_back(ucnt);
    end
  end

  always @(negedge clk) begin : capture
    int issued;
    if (rstn && wbeat) begin
      if (exp_data.size() == 0) begin
        $display("Unexpected write beat at %0t ns with no read pending", $time);
        other_errs++;
      end else begin
        beats_seen++;
        check_word("wdata_o", wdata, exp_data.pop_front());
        check_strb("wstrb_o", wstrb, exp_strb.pop_front());
        check_addr("waddr_o", waddr, exp_addr.pop_front());
        check_size("xfer_size_o", xfer_size, exp_size.pop_front());
        issued = (issue_q.size() != 0) ? issue_q.pop_front() : -10;
        if (ucnt - issued != 1) begin
          $display("Write beat %0d came %0d unstalled cycles after its read pulse",
                   beats_seen, ucnt - issued + 1);
          other_errs++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Command tasks, all start and end 1 ns after a rising edge

  task automatic drain_beats();
    int n;
    n = 0;
    while (exp_data.size() != 0 && n < 20) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (exp_data.size() != 0) begin
      $display("%0d expected write beats never arrived", exp_data.size());
      other_errs++;
      exp_data.delete();
      exp_strb.delete();
      exp_addr.delete();
      exp_size.delete();
    end
  endtask

  task automatic apply_cfg(input string s);
    int v_sew, v_grow, v_shift, v_vlenb, v_type, v_base, v_stride;
    drain_beats();  // Mode change must not hit beats in flight
    if ($sscanf(s, "C %h %h %h %h %h %h %h %h %h", v_sew, v_grow, v_shift, v_vlenb,
                v_type, v_base, v_stride, exp_wr_beats, exp_rd_beats) != 9) begin
      $display("Malformed configuration line in vectors file: %s", s);
      other_errs++;
    end else begin
      sew        = vec_cfg_pkg::sew_e'(v_sew[1:0]);
      lmul_grow  = v_grow[0];
      lmul_shift = v_shift[1:0];
      vlenb      = v_vlenb[7:0];
      store_type = mem_xfer_pkg::store_type_e'(v_type[0]);
      base_addr  = v_base;
      stride     = v_stride;
      cfg_update = 1'b1;
      cntr_rst   = 1'b1;
      addr_load  = 1'b1;
      @(posedge clk);
      #1;
      cfg_update = 1'b0;
      cntr_rst   = 1'b0;
      addr_load  = 1'b0;
      wr_cnt     = 0;
      rd_cnt     = 0;
      check_level("not_empty_o", not_empty, 1'b0, "after a counter reset");
      check_level("write_done_o", write_done, 1'b0, "after a counter reset");
      check_level("read_done_o", read_done, 1'b0, "after a counter reset");
    end
  endtask

  task automatic write_beat(input string s);
    int l0, l1, l2, l3;
    if ($sscanf(s, "W %h %h %h %h", l0, l1, l2, l3) != 4) begin
      $display("Malformed write line in vectors file: %s", s);
      other_errs++;
    end else begin
      lane_data[0] = l0;
      lane_data[1] = l1;
      lane_data[2] = l2;
      lane_data[3] = l3;
      wen = 1'b1;
      @(posedge clk);
      #1;
      wen = 1'b0;
      wr_cnt++;
      check_level("not_empty_o", not_empty, 1'b1, "after a write beat");
      check_level("write_done_o", write_done, wr_cnt == exp_wr_beats,
                  $sformatf("after write beat %0d of %0d", wr_cnt, exp_wr_beats));
    end
  endtask

  task automatic read_beat(input string s);
    int v_data, v_strb, v_addr, v_size, v_stall;
    int gap;
    if ($sscanf(s, "R %h %h %h %h %h", v_data, v_strb, v_addr, v_size, v_stall) != 5) begin
      $display("Malformed read line in vectors file: %s", s);
      other_errs++;
    end else begin
      exp_data.push_back(v_data);
      exp_strb.push_back(v_strb[3:0]);
      exp_addr.push_back(v_addr);
      exp_size.push_back(v_size[15:0]);
      rd_en = 1'b1;
      @(posedge clk);
      #1;
      rd_en = 1'b0;
      rd_cnt++;
      check_level("read_done_o", read_done, rd_cnt == exp_rd_beats,
                  $sformatf("after read beat %0d of %0d", rd_cnt, exp_rd_beats));
      if (v_stall != 0) begin
        gap   = 1 + ($urandom % 3);  // Freezes the beats in flight
        stall = 1'b1;
        repeat (gap) @(posedge clk);
        #1;
        stall = 1'b0;
      end
    end
  endtask

  task automatic load_vectors();
    int    fd;
    string s;
    fd = $fopen("testbench/store_vectors.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        if ($fgets(s, fd) != 0) lines.push_back(s);
      end
      $fclose(fd);
    end
    loaded = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog

  initial begin : main
    string s;
    rstn       = 1'b0;
    cfg_update = 1'b0;
    lmul_grow  = 1'b0;
    lmul_shift = 2'd0;
    sew        = vec_cfg_pkg::SEW32;
    vlenb      = '0;
    store_type = mem_xfer_pkg::ST_UNIT;
    cntr_rst   = 1'b0;
    wen        = 1'b0;
    rd_en      = 1'b0;
    stall      = 1'b0;
    flush      = 1'b0;
    addr_load  = 1'b0;
    base_addr  = '0;
    stride     = '0;
    foreach (lane_data[i]) lane_data[i] = '0;
    void'($urandom(SEED));
    load_vectors();
    if (lines.size() == 0) begin
      $display("Vectors file testbench/store_vectors.txt is missing or empty");
      other_errs++;
    end else begin
      repeat (5) @(posedge clk);
      #1;
      rstn = 1'b1;
      check_level("wbeat_o", wbeat, 1'b0, "after reset");
      check_level("not_empty_o", not_empty, 1'b0, "after reset");
      check_level("write_done_o", write_done, 1'b0, "after reset");
      check_level("read_done_o", read_done, 1'b0, "after reset");
      check_strb("wstrb_o", wstrb, 4'b0000);
      foreach (lines[i]) begin
        s = lines[i];
        if (s.len() > 1 && s[0] != "#") begin
          case (s[0])
            "C":     apply_cfg(s);
            "W":     write_beat(s);
            "R":     read_beat(s);
            default: begin
              $display("Unknown command on vectors line %0d", i + 1);
              other_errs++;
            end
          endcase
        end
      end
      drain_beats();
    end
    $display("Closing: %0d mismatches, %0d other errors, %0d beats checked",
             mismatches, other_errs, beats_seen);
    if (mismatches + other_errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    wait (loaded);
    #(lines.size() * 50 * PERIOD);
    $display("Timeout: run exceeded %0d cycles for %0d vectors lines",
             lines.size() * 50, lines.size());
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== testbench/store_vectors.txt ====
# C sew grow shift vlenb type base stride wr_beats rd_beats | W lane0 lane1 lane2 lane3
# R data strb addr xfer_size stall | all fields hex, stall 1 adds random stall cycles
C 2 0 0 10 0 00001000 0 1 4
W 0badf00d 12345678 9abcdef0 c001d00d
R 0badf00d f 00001000 0010 0
R 12345678 f 00001000 0010 1
R 9abcdef0 f 00001000 0010 0
R c001d00d f 00001000 0010 0
C 0 1 2 10 0 00002000 0 10 10
W a5a5a510 5a5a5a11 ffffff12 00000013
W a5a5a514 5a5a5a15 ffffff16 00000017
W a5a5a518 5a5a5a19 ffffff1a 0000001b
W a5a5a51c 5a5a5a1d ffffff1e 0000001f
W a5a5a520 5a5a5a21 ffffff22 00000023
W a5a5a524 5a5a5a25 ffffff26 00000027
W a5a5a528 5a5a5a29 ffffff2a 0000002b
W a5a5a52c 5a5a5a2d ffffff2e 0000002f
W a5a5a530 5a5a5a31 ffffff32 00000033
W a5a5a534 5a5a5a35 ffffff36 00000037
W a5a5a538 5a5a5a39 ffffff3a 0000003b
W a5a5a53c 5a5a5a3d ffffff3e 0000003f
W a5a5a540 5a5a5a41 ffffff42 00000043
W a5a5a544 5a5a5a45 ffffff46 00000047
W a5a5a548 5a5a5a49 ffffff4a 0000004b
W a5a5a54c 5a5a5a4d ffffff4e 0000004f
R 13121110 f 00002000 0040 0
R 17161514 f 00002000 0040 0
R 1b1a1918 f 00002000 0040 1
R 1f1e1d1c f 00002000 0040 0
R 23222120 f 00002000 0040 0
R 27262524 f 00002000 0040 1
R 2b2a2928 f 00002000 0040 1
R 2f2e2d2c f 00002000 0040 0
R 33323130 f 00002000 0040 0
R 37363534 f 00002000 0040 0
R 3b3a3938 f 00002000 0040 0
R 3f3e3d3c f 00002000 0040 1
R 43424140 f 00002000 0040 0
R 47464544 f 00002000 0040 0
R 4b4a4948 f 00002000 0040 0
R 4f4e4d4c f 00002000 0040 1
C 1 0 0 08 1 00003002 6 1 4
W 3333a001 3333b002 3333c003 3333d004
R a0010000 c 00003002 0002 1
R 0000b002 3 00003008 0002 0
R c0030000 c 0000300e 0002 1
R 0000d004 3 00003014 0002 0
C 0 0 1 10 0 00004000 0 2 2
W 5a5a5a80 5a5a5a81 5a5a5a82 5a5a5a83
W 5a5a5a84 5a5a5a85 5a5a5a86 5a5a5a87
R 83828180 f 00004000 0008 1
R 87868584 f 00004000 0008 0

// ==== files.f ====
logic/vec_cfg_pkg.sv
logic/mem_xfer_pkg.sv
logic/store_len_calc.sv
logic/lane_pack_writer.sv
logic/lane_buffer_ram.sv
logic/store_serializer.sv
logic/store_buffer_top.sv
testbench/tb_store_buffer.sv

// ==== Bender.yml ====
package:
  name: vector_store_buffer

sources:
  - logic/vec_cfg_pkg.sv
  - logic/mem_xfer_pkg.sv
  - logic/store_len_calc.sv
  - logic/lane_pack_writer.sv
  - logic/lane_buffer_ram.sv
  - logic/store_serializer.sv
  - logic/store_buffer_top.sv
  - target: simulation
    files:
      - testbench/tb_store_buffer.sv
